/* logic/csr_file.sv */
`timescale 1ns/100ps

module csr_file (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [pipeline_pkg::CSR_ADDR_W-1:0]  csr_raddr,
    input  logic                                 fwd_csr_we,
    input  logic [pipeline_pkg::CSR_ADDR_W-1:0]  fwd_csr_addr,
    input  logic [31:0]                          fwd_csr_wdata,
    input  logic                                 fwd_ll_we,
    input  logic                                 fwd_ll_data,
    output logic [31:0]                          csr_rdata,
    output logic                                 ll_bit,
    output logic [63:0]                          cnt
);

    logic [31:0] save0;
    logic [31:0] tid;

    always_ff @(posedge clk) begin
        if (rst) begin
            save0  <= 32'b0;
            tid    <= pipeline_pkg::TID_RESET;
            ll_bit <= 1'b0;
            cnt    <= 64'b0;
        end else begin
            // Stable counter runs freely.
            cnt <= cnt + 64'd1;
            if (fwd_ll_we) begin
                ll_bit <= fwd_ll_data;
            end
            if (fwd_csr_we && fwd_csr_addr == pipeline_pkg::CSR_SAVE0) begin
                save0 <= fwd_csr_wdata;
            end
            if (fwd_csr_we && fwd_csr_addr == pipeline_pkg::CSR_TID) begin
                tid <= fwd_csr_wdata;
            end
        end
    end

    always_comb begin
        case (csr_raddr)
            pipeline_pkg::CSR_SAVE0: csr_rdata = save0;
            pipeline_pkg::CSR_TID:   csr_rdata = tid;
            default:                 csr_rdata = 32'b0;
        endcase
    end

endmodule

/* logic/data_ram.sv */
`timescale 1ns/100ps

module data_ram (
    input  logic        clk,
    input  logic        rst,
    input  logic        ram_req,
    input  logic        ram_we,
    input  logic [31:0] ram_addr,
    input  logic [31:0] ram_wdata,
    input  logic [3:0]  ram_wstrb,
    output logic        ram_data_ok,
    output logic [31:0] ram_rdata
);

    logic [31:0] mem [pipeline_pkg::RAM_WORDS];

    logic [pipeline_pkg::RAM_AW-1:0] index;
    logic                            slow;
    logic                            accept;
    logic                            busy;
    logic [pipeline_pkg::WAIT_W-1:0] wait_cnt;
    logic                            finish;

    assign index  = ram_addr[pipeline_pkg::RAM_AW+1:2];
    assign slow   = ram_addr[6];
    assign accept = ram_req && !busy && !ram_data_ok;
    assign finish = busy && (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            wait_cnt    <= '0;
            ram_data_ok <= 1'b0;
            for (int i = 0; i < pipeline_pkg::RAM_WORDS; i++) begin
                mem[i] <= 32'b0;
            end
        end else begin
            ram_data_ok <= 1'b0;
            if (accept) begin
                if (ram_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (ram_wstrb[b]) begin
                            mem[index][8*b +: 8] <= ram_wdata[8*b +: 8];
                        end
                    end
                end
                if (slow) begin
                    busy     <= 1'b1;
                    wait_cnt <= pipeline_pkg::WAIT_W'(pipeline_pkg::MISS_DELAY - 1);
                end else begin
                    ram_data_ok <= 1'b1;
                end
            end else if (finish) begin
                busy        <= 1'b0;
                ram_data_ok <= 1'b1;
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // Read word follows data_ok.
    always_ff @(posedge clk) begin
        if ((accept && !slow) || finish) begin
            ram_rdata <= mem[index];
        end
    end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
    input  logic                                 ex_valid,
    input  pipeline_pkg::mem_op_t                ex_op,
    input  logic [31:0]                          ex_addr,
    input  logic [31:0]                          ex_store_data,
    input  logic [4:0]                           ex_rd,
    input  logic [pipeline_pkg::CSR_ADDR_W-1:0]  ex_csr_addr,
    input  logic [31:0]                          ex_csr_wdata,
    input  logic [31:0]                          ex_csr_mask,
    input  logic                                 ram_data_ok,
    input  logic [31:0]                          ram_rdata,
    input  logic [31:0]                          csr_rdata,
    input  logic                                 ll_bit,
    input  logic [63:0]                          cnt,
    input  logic                                 fwd_csr_we,
    input  logic [pipeline_pkg::CSR_ADDR_W-1:0]  fwd_csr_addr,
    input  logic [31:0]                          fwd_csr_wdata,
    input  logic                                 fwd_ll_we,
    input  logic                                 fwd_ll_data,
    output logic                                 ex_ready,
    output logic                                 ram_req,
    output logic                                 ram_we,
    output logic [31:0]                          ram_addr,
    output logic [31:0]                          ram_wdata,
    output logic [3:0]                           ram_wstrb,
    output logic [pipeline_pkg::CSR_ADDR_W-1:0]  csr_raddr,
    output logic                                 mem_valid,
    output logic                                 mem_we,
    output logic [4:0]                           mem_rd,
    output logic [31:0]                          mem_data,
    output pipeline_pkg::exc_cause_t             mem_exc,
    output logic                                 mem_csr_we,
    output logic [pipeline_pkg::CSR_ADDR_W-1:0]  mem_csr_addr,
    output logic [31:0]                          mem_csr_wdata,
    output logic                                 mem_ll_we,
    output logic                                 mem_ll_data
);

    logic [1:0]  lane;
    logic        half_mis;
    logic        word_mis;
    logic        need_ram;
    logic        ll_eff;
    logic [31:0] csr_old;
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign lane     = ex_addr[1:0];
    assign half_mis = lane[0];
    assign word_mis = |lane;

    // LL bit as seen after the writeback bypass.
    assign ll_eff = fwd_ll_we ? fwd_ll_data : ll_bit;

    assign csr_raddr = (ex_op == pipeline_pkg::OP_RDCNTID) ? pipeline_pkg::CSR_TID : ex_csr_addr;
    assign csr_old   = (fwd_csr_we && fwd_csr_addr == csr_raddr) ? fwd_csr_wdata : csr_rdata;

    assign load_byte = ram_rdata[{lane, 3'b000} +: 8];
    assign load_half = lane[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    //////////////////////////////
    // Handshakes.
    assign ram_addr  = {ex_addr[31:2], 2'b00};
    assign ram_req   = ex_valid && need_ram;
    assign ex_ready  = !need_ram || ram_data_ok;
    assign mem_valid = ex_valid && ex_ready;

    assign mem_rd       = ex_rd;
    assign mem_csr_addr = csr_raddr;

    //////////////////////////////
    // Operation decode.
    always_comb begin
        need_ram      = 1'b0;
        ram_we        = 1'b0;
        ram_wdata     = ex_store_data;
        ram_wstrb     = 4'b0000;
        mem_we        = 1'b0;
        mem_data      = 32'b0;
        mem_exc       = pipeline_pkg::EXC_NONE;
        mem_csr_we    = 1'b0;
        mem_csr_wdata = ex_csr_wdata;
        mem_ll_we     = 1'b0;
        mem_ll_data   = 1'b0;

        case (ex_op)
            pipeline_pkg::OP_LDB: begin
                need_ram = 1'b1;
                mem_we   = 1'b1;
                mem_data = {{24{load_byte[7]}}, load_byte};
            end
            pipeline_pkg::OP_LDBU: begin
                need_ram = 1'b1;
                mem_we   = 1'b1;
                mem_data = {24'b0, load_byte};
            end
            pipeline_pkg::OP_LDH, pipeline_pkg::OP_LDHU: begin
                mem_we = 1'b1;
                if (half_mis) begin
                    mem_exc = pipeline_pkg::EXC_ALE;
                end else begin
                    need_ram = 1'b1;
                end
                if (ex_op == pipeline_pkg::OP_LDH) begin
                    mem_data = {{16{load_half[15]}}, load_half};
                end else begin
                    mem_data = {16'b0, load_half};
                end
            end
            pipeline_pkg::OP_LDW, pipeline_pkg::OP_LLW: begin
                mem_we   = 1'b1;
                mem_data = ram_rdata;
                if (word_mis) begin
                    mem_exc = pipeline_pkg::EXC_ALE;
                end else begin
                    need_ram = 1'b1;
                end
                if (ex_op == pipeline_pkg::OP_LLW) begin
                    mem_ll_we   = 1'b1;
                    mem_ll_data = 1'b1;
                end
            end
            pipeline_pkg::OP_STB: begin
                need_ram  = 1'b1;
                ram_we    = 1'b1;
                ram_wdata = {4{ex_store_data[7:0]}};
                ram_wstrb = 4'b0001 << lane;
            end
            pipeline_pkg::OP_STH: begin
                ram_wdata = {2{ex_store_data[15:0]}};
                if (half_mis) begin
                    mem_exc = pipeline_pkg::EXC_ALE;
                end else begin
                    need_ram  = 1'b1;
                    ram_we    = 1'b1;
                    ram_wstrb = lane[1] ? 4'b1100 : 4'b0011;
                end
            end
            pipeline_pkg::OP_STW: begin
                if (word_mis) begin
                    mem_exc = pipeline_pkg::EXC_ALE;
                end else begin
                    need_ram  = 1'b1;
                    ram_we    = 1'b1;
                    ram_wstrb = 4'b1111;
                end
            end
            pipeline_pkg::OP_SCW: begin
                mem_we = 1'b1;
                if (word_mis) begin
                    mem_exc = pipeline_pkg::EXC_ALE;
                end else if (ll_eff) begin
                    // Success consumes the reservation.
                    need_ram    = 1'b1;
                    ram_we      = 1'b1;
                    ram_wstrb   = 4'b1111;
                    mem_data    = 32'd1;
                    mem_ll_we   = 1'b1;
                    mem_ll_data = 1'b0;
                end
            end
            pipeline_pkg::OP_CSRRD, pipeline_pkg::OP_RDCNTID: begin
                mem_we   = 1'b1;
                mem_data = csr_old;
            end
            pipeline_pkg::OP_CSRWR: begin
                mem_we     = 1'b1;
                mem_data   = csr_old;
                mem_csr_we = 1'b1;
            end
            pipeline_pkg::OP_CSRXCHG: begin
                mem_we        = 1'b1;
                mem_data      = csr_old;
                mem_csr_we    = 1'b1;
                mem_csr_wdata = (csr_old & ~ex_csr_mask) | (ex_csr_wdata & ex_csr_mask);
            end
            pipeline_pkg::OP_RDCNTVLW: begin
                mem_we   = 1'b1;
                mem_data = cnt[31:0];
            end
            pipeline_pkg::OP_RDCNTVHW: begin
                mem_we   = 1'b1;
                mem_data = cnt[63:32];
            end
            default: begin
            end
        endcase
    end

endmodule

/* logic/mem_subsystem.sv */
`timescale 1ns/100ps

module mem_subsystem (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 ex_valid,
    input  pipeline_pkg::mem_op_t                ex_op,
    input  logic [31:0]                          ex_addr,
    input  logic [31:0]                          ex_store_data,
    input  logic [4:0]                           ex_rd,
    input  logic [pipeline_pkg::CSR_ADDR_W-1:0]  ex_csr_addr,
    input  logic [31:0]                          ex_csr_wdata,
    input  logic [31:0]                          ex_csr_mask,
    output logic                                 ex_ready,
    output logic                                 wb_valid,
    output logic                                 wb_we,
    output logic [4:0]                           wb_rd,
    output logic [31:0]                          wb_data,
    output pipeline_pkg::exc_cause_t             wb_exc
);

    //////////////////////////////
    // Stage to RAM.
    logic        ram_req;
    logic        ram_we;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [3:0]  ram_wstrb;
    logic        ram_data_ok;
    logic [31:0] ram_rdata;

    //////////////////////////////
    // CSR block.
    logic [pipeline_pkg::CSR_ADDR_W-1:0] csr_raddr;
    logic [31:0]                         csr_rdata;
    logic                                ll_bit;
    logic [63:0]                         cnt;

    //////////////////////////////
    // Stage to writeback and forward bundle.
    logic                                mem_valid;
    logic                                mem_we;
    logic [4:0]                          mem_rd;
    logic [31:0]                         mem_data;
    pipeline_pkg::exc_cause_t            mem_exc;
    logic                                mem_csr_we;
    logic [pipeline_pkg::CSR_ADDR_W-1:0] mem_csr_addr;
    logic [31:0]                         mem_csr_wdata;
    logic                                mem_ll_we;
    logic                                mem_ll_data;
    logic                                fwd_csr_we;
    logic [pipeline_pkg::CSR_ADDR_W-1:0] fwd_csr_addr;
    logic [31:0]                         fwd_csr_wdata;
    logic                                fwd_ll_we;
    logic                                fwd_ll_data;

    mem_stage u_mem_stage (.*);

    data_ram u_data_ram (.*);

    csr_file u_csr_file (.*);

    mem_wb_reg u_mem_wb_reg (.*);

endmodule

/* logic/mem_wb_reg.sv */
`timescale 1ns/100ps

module mem_wb_reg (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 mem_valid,
    input  logic                                 mem_we,
    input  logic [4:0]                           mem_rd,
    input  logic [31:0]                          mem_data,
    input  pipeline_pkg::exc_cause_t             mem_exc,
    input  logic                                 mem_csr_we,
    input  logic [pipeline_pkg::CSR_ADDR_W-1:0]  mem_csr_addr,
    input  logic [31:0]                          mem_csr_wdata,
    input  logic                                 mem_ll_we,
    input  logic                                 mem_ll_data,
    output logic                                 wb_valid,
    output logic                                 wb_we,
    output logic [4:0]                           wb_rd,
    output logic [31:0]                          wb_data,
    output pipeline_pkg::exc_cause_t             wb_exc,
    output logic                                 fwd_csr_we,
    output logic [pipeline_pkg::CSR_ADDR_W-1:0]  fwd_csr_addr,
    output logic [31:0]                          fwd_csr_wdata,
    output logic                                 fwd_ll_we,
    output logic                                 fwd_ll_data
);

    logic commit;

    // Faulting instructions retire without side effects.
    assign commit = mem_valid && (mem_exc == pipeline_pkg::EXC_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid   <= 1'b0;
            wb_we      <= 1'b0;
            fwd_csr_we <= 1'b0;
            fwd_ll_we  <= 1'b0;
        end else begin
            wb_valid   <= mem_valid;
            wb_we      <= commit && mem_we;
            fwd_csr_we <= commit && mem_csr_we;
            fwd_ll_we  <= commit && mem_ll_we;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_rd         <= mem_rd;
            wb_data       <= mem_data;
            wb_exc        <= mem_exc;
            fwd_csr_addr  <= mem_csr_addr;
            fwd_csr_wdata <= mem_csr_wdata;
            fwd_ll_data   <= mem_ll_data;
        end
    end

endmodule

/* logic/pipeline_pkg.sv */
package pipeline_pkg;

    //////////////////////////////
    // Operations in the memory stage.
    typedef enum logic [4:0] {
        OP_NOP,
        OP_LDB,
        OP_LDBU,
        OP_LDH,
        OP_LDHU,
        OP_LDW,
        OP_STB,
        OP_STH,
        OP_STW,
        OP_LLW,
        OP_SCW,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_RDCNTID,
        OP_RDCNTVLW,
        OP_RDCNTVHW
    } mem_op_t;

    // Exceptions raised here.
    typedef enum logic {
        EXC_NONE,
        EXC_ALE
    } exc_cause_t;

    //////////////////////////////
    // CSR map.
    localparam int CSR_ADDR_W = 14;

    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0 = 14'h030;
    localparam logic [CSR_ADDR_W-1:0] CSR_TID   = 14'h040;

    // TID value out of reset.
    localparam logic [31:0] TID_RESET = 32'd5;

    //////////////////////////////
    // Data RAM geometry and timing.
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // Extra cycles for addresses with bit 6 set.
    localparam int MISS_DELAY = 3;
    localparam int WAIT_W     = $clog2(MISS_DELAY + 1);

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/100ps -f tb.f --top-module tb_mem_subsystem \
    -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* tb.f */
+incdir+test
logic/pipeline_pkg.sv
logic/data_ram.sv
logic/csr_file.sv
logic/mem_stage.sv
logic/mem_wb_reg.sv
logic/mem_subsystem.sv
test/tb_mem_subsystem.sv

/* test/tb_vectors.svh */
// Memory rows: op, address, store data, ALE expected, expected data, check data,
// random group (0 fixed, 1 fast random, 2 slow random).
// CSR rows: op, CSR address, write data, mask, expected data, check data.

// Word at a fast address, then its lanes.
mem_row(pipeline_pkg::OP_STW,  32'h010, 32'h8899_aabb, 1'b0, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_LDW,  32'h010, 32'h0,         1'b0, 32'h8899_aabb, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDB,  32'h010, 32'h0,         1'b0, 32'hffff_ffbb, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDB,  32'h011, 32'h0,         1'b0, 32'hffff_ffaa, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDBU, 32'h012, 32'h0,         1'b0, 32'h0000_0099, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDBU, 32'h013, 32'h0,         1'b0, 32'h0000_0088, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDH,  32'h010, 32'h0,         1'b0, 32'hffff_aabb, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDHU, 32'h012, 32'h0,         1'b0, 32'h0000_8899, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDH,  32'h012, 32'h0,         1'b0, 32'hffff_8899, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_STB,  32'h011, 32'h0000_0042, 1'b0, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_LDW,  32'h010, 32'h0,         1'b0, 32'h8899_42bb, 1'b1, 2'd0);

// Slow address, bit 6 set.
mem_row(pipeline_pkg::OP_STW,  32'h050, 32'h1234_f0e1, 1'b0, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_LDB,  32'h051, 32'h0,         1'b0, 32'hffff_fff0, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDHU, 32'h050, 32'h0,         1'b0, 32'h0000_f0e1, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_STH,  32'h052, 32'h0000_7777, 1'b0, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_LDW,  32'h050, 32'h0,         1'b0, 32'h7777_f0e1, 1'b1, 2'd0);

// Random words, fast then slow.
mem_row(pipeline_pkg::OP_STW,  32'h0,   32'h0,         1'b0, 32'h0000_0000, 1'b0, 2'd1);
mem_row(pipeline_pkg::OP_LDW,  32'h0,   32'h0,         1'b0, 32'h0000_0000, 1'b1, 2'd1);
mem_row(pipeline_pkg::OP_LDB,  32'h3,   32'h0,         1'b0, 32'h0000_0000, 1'b1, 2'd1);
mem_row(pipeline_pkg::OP_LDHU, 32'h2,   32'h0,         1'b0, 32'h0000_0000, 1'b1, 2'd1);
mem_row(pipeline_pkg::OP_STW,  32'h0,   32'h0,         1'b0, 32'h0000_0000, 1'b0, 2'd2);
mem_row(pipeline_pkg::OP_LDBU, 32'h1,   32'h0,         1'b0, 32'h0000_0000, 1'b1, 2'd2);
mem_row(pipeline_pkg::OP_LDH,  32'h0,   32'h0,         1'b0, 32'h0000_0000, 1'b1, 2'd2);

// Misaligned accesses, then the word is read back unchanged.
mem_row(pipeline_pkg::OP_LDH,  32'h011, 32'h0,         1'b1, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_LDW,  32'h012, 32'h0,         1'b1, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_STH,  32'h013, 32'hdead_beef, 1'b1, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_STW,  32'h011, 32'hdead_beef, 1'b1, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_LLW,  32'h012, 32'h0,         1'b1, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_SCW,  32'h011, 32'hdead_beef, 1'b1, 32'h0000_0000, 1'b0, 2'd0);
mem_row(pipeline_pkg::OP_LDW,  32'h010, 32'h0,         1'b0, 32'h8899_42bb, 1'b1, 2'd0);

// LL/SC.
mem_row(pipeline_pkg::OP_SCW,  32'h020, 32'h5555_aaaa, 1'b0, 32'h0000_0000, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDW,  32'h020, 32'h0,         1'b0, 32'h0000_0000, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LLW,  32'h020, 32'h0,         1'b0, 32'h0000_0000, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_SCW,  32'h020, 32'h5555_aaaa, 1'b0, 32'h0000_0001, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_SCW,  32'h020, 32'h1111_1111, 1'b0, 32'h0000_0000, 1'b1, 2'd0);
mem_row(pipeline_pkg::OP_LDW,  32'h020, 32'h0,         1'b0, 32'h5555_aaaa, 1'b1, 2'd0);

// CSR access and counters.
csr_row(pipeline_pkg::OP_CSRWR,    14'h030, 32'hcafe_0001, 32'h0,         32'h0000_0000, 1'b1);
csr_row(pipeline_pkg::OP_CSRRD,    14'h030, 32'h0,         32'h0,         32'hcafe_0001, 1'b1);
csr_row(pipeline_pkg::OP_CSRXCHG,  14'h030, 32'h1234_5678, 32'hffff_0000, 32'hcafe_0001, 1'b1);
csr_row(pipeline_pkg::OP_CSRRD,    14'h030, 32'h0,         32'h0,         32'h1234_0001, 1'b1);
csr_row(pipeline_pkg::OP_RDCNTID,  14'h000, 32'h0,         32'h0,         32'h0000_0005, 1'b1);
csr_row(pipeline_pkg::OP_RDCNTVLW, 14'h000, 32'h0,         32'h0,         32'h0000_0000, 1'b0);
csr_row(pipeline_pkg::OP_RDCNTVLW, 14'h000, 32'h0,         32'h0,         32'h0000_0000, 1'b0);
csr_row(pipeline_pkg::OP_RDCNTVHW, 14'h000, 32'h0,         32'h0,         32'h0000_0000, 1'b1);

/* test/tb_mem_subsystem.sv */
`timescale 1ns/100ps

module tb_mem_subsystem;

    typedef struct {
        pipeline_pkg::mem_op_t               op;
        logic [31:0]                         addr;
        logic [31:0]                         sdata;
        logic [pipeline_pkg::CSR_ADDR_W-1:0] csr;
        logic [31:0]                         wdata;
        logic [31:0]                         mask;
        logic [4:0]                          rd;
        logic                                ale;
        logic [31:0]                         want;
        logic                                chk;
        logic [1:0]                          rnd;
    } vec_t;

    logic                                clk;
    logic                                rst;
    logic                                ex_valid;
    pipeline_pkg::mem_op_t               ex_op;
    logic [31:0]                         ex_addr;
    logic [31:0]                         ex_store_data;
    logic [4:0]                          ex_rd;
    logic [pipeline_pkg::CSR_ADDR_W-1:0] ex_csr_addr;
    logic [31:0]                         ex_csr_wdata;
    logic [31:0]                         ex_csr_mask;
    logic                                ex_ready;
    logic                                wb_valid;
    logic                                wb_we;
    logic [4:0]                          wb_rd;
    logic [31:0]                         wb_data;
    pipeline_pkg::exc_cause_t            wb_exc;

    vec_t        rows[$];
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] last_cnt;
    logic        have_cnt;

    mem_subsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Table construction.
    task automatic mem_row(input pipeline_pkg::mem_op_t op, input logic [31:0] addr,
                           input logic [31:0] sdata, input logic ale,
                           input logic [31:0] want, input logic chk, input logic [1:0] rnd);
        vec_t v;
        v.op    = op;
        v.addr  = addr;
        v.sdata = sdata;
        v.csr   = '0;
        v.wdata = 32'b0;
        v.mask  = 32'b0;
        v.rd    = 5'(rows.size() + 1);
        v.ale   = ale;
        v.want  = want;
        v.chk   = chk;
        v.rnd   = rnd;
        rows.push_back(v);
    endtask

    task automatic csr_row(input pipeline_pkg::mem_op_t op,
                           input logic [pipeline_pkg::CSR_ADDR_W-1:0] csr,
                           input logic [31:0] wdata, input logic [31:0] mask,
                           input logic [31:0] want, input logic chk);
        vec_t v;
        v.op    = op;
        v.addr  = 32'b0;
        v.sdata = 32'b0;
        v.csr   = csr;
        v.wdata = wdata;
        v.mask  = mask;
        v.rd    = 5'(rows.size() + 1);
        v.ale   = 1'b0;
        v.want  = want;
        v.chk   = chk;
        v.rnd   = 2'd0;
        rows.push_back(v);
    endtask

    task automatic load_table();
        `include "tb_vectors.svh"
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_store(input pipeline_pkg::mem_op_t op);
        return op inside {pipeline_pkg::OP_STB, pipeline_pkg::OP_STH, pipeline_pkg::OP_STW};
    endfunction

    // Cycles ex_ready stays low, fast or slow RAM, none without an access.
    function automatic int ready_wait(input vec_t r);
        logic uses_ram;
        uses_ram = !r.ale && ((r.op inside {pipeline_pkg::OP_LDB, pipeline_pkg::OP_LDBU,
                                            pipeline_pkg::OP_LDH, pipeline_pkg::OP_LDHU,
                                            pipeline_pkg::OP_LDW, pipeline_pkg::OP_STB,
                                            pipeline_pkg::OP_STH, pipeline_pkg::OP_STW,
                                            pipeline_pkg::OP_LLW})
                              || (r.op == pipeline_pkg::OP_SCW && r.want == 32'd1));
        if (!uses_ram) begin
            return 0;
        end
        return r.addr[6] ? 1 + pipeline_pkg::MISS_DELAY : 1;
    endfunction

    // Load result from a word, by lane and extension.
    function automatic logic [31:0] lane_value(input pipeline_pkg::mem_op_t op,
                                               input logic [31:0] w, input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            pipeline_pkg::OP_LDB:  return {{24{b[7]}}, b};
            pipeline_pkg::OP_LDBU: return {24'b0, b};
            pipeline_pkg::OP_LDH:  return {{16{h[15]}}, h};
            pipeline_pkg::OP_LDHU: return {16'b0, h};
            default:               return w;
        endcase
    endfunction

    // Random bases sit above 0x200, clear of the fixed rows.
    task automatic fill_random();
        logic [31:0] seed;
        logic [31:0] base [2];
        logic [31:0] word [2];
        logic [1:0]  off;
        int          g;
        seed = 32'hde08d525;
        for (int k = 0; k < 2; k++) begin
            seed    = lcg_next(seed);
            base[k] = 32'h200 | ((k == 1) ? 32'h040 : 32'h000) | (seed & 32'h1bc);
            seed    = lcg_next(seed);
            word[k] = seed;
        end
        foreach (rows[i]) begin
            if (rows[i].rnd != 2'd0) begin
                g             = int'(rows[i].rnd) - 1;
                off           = rows[i].addr[1:0];
                rows[i].addr  = base[g] + {30'b0, off};
                rows[i].sdata = word[g];
                if (!is_store(rows[i].op)) begin
                    rows[i].want = lane_value(rows[i].op, word[g], off);
                end
            end
        end
    endtask

    //////////////////////////////
    // Checking.
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic score_row(input int idx);
        vec_t                     r;
        pipeline_pkg::exc_cause_t want_exc;
        logic                     want_we;
        r        = rows[idx];
        want_exc = r.ale ? pipeline_pkg::EXC_ALE : pipeline_pkg::EXC_NONE;
        want_we  = !r.ale && !is_store(r.op);
        compare_value($sformatf("wb_exc row %0d", idx), 32'(wb_exc), 32'(want_exc));
        compare_value($sformatf("wb_we row %0d", idx), 32'(wb_we), 32'(want_we));
        compare_value($sformatf("wb_rd row %0d", idx), 32'(wb_rd), 32'(r.rd));
        if (r.chk) begin
            compare_value($sformatf("wb_data row %0d", idx), wb_data, r.want);
        end
        // Counter low word must keep rising.
        if (r.op == pipeline_pkg::OP_RDCNTVLW) begin
            if (have_cnt) begin
                compare_value($sformatf("wb_data rise row %0d", idx),
                              32'(wb_data > last_cnt), 32'd1);
            end
            last_cnt = wb_data;
            have_cnt = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout waiting for writeback");
            $display("errors: %0d", errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus loop.
    initial begin
        int n;
        int waits;
        rst           = 1'b1;
        ex_valid      = 1'b0;
        ex_op         = pipeline_pkg::OP_NOP;
        ex_addr       = 32'b0;
        ex_store_data = 32'b0;
        ex_rd         = 5'b0;
        ex_csr_addr   = '0;
        ex_csr_wdata  = 32'b0;
        ex_csr_mask   = 32'b0;
        have_cnt      = 1'b0;
        last_cnt      = 32'b0;
        load_table();
        fill_random();
        n     = rows.size();
        limit = n * (pipeline_pkg::MISS_DELAY + 6) + 2;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Next row goes out on the edge that accepts the previous one.
        for (int i = 0; i < n; i++) begin
            ex_valid      <= 1'b1;
            ex_op         <= rows[i].op;
            ex_addr       <= rows[i].addr;
            ex_store_data <= rows[i].sdata;
            ex_rd         <= rows[i].rd;
            ex_csr_addr   <= rows[i].csr;
            ex_csr_wdata  <= rows[i].wdata;
            ex_csr_mask   <= rows[i].mask;
            @(negedge clk);
            if (i > 0) begin
                while (!wb_valid) @(negedge clk);
                score_row(i - 1);
            end
            waits = 0;
            while (!ex_ready) begin
                @(negedge clk);
                waits++;
            end
            compare_value($sformatf("ex_ready wait row %0d", i), 32'(waits),
                          32'(ready_wait(rows[i])));
            @(posedge clk);
        end
        ex_valid <= 1'b0;
        @(negedge clk);
        while (!wb_valid) @(negedge clk);
        score_row(n - 1);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
